// File: verilog/hbus_pkg.sv
/*
 * Shared widths and bus bundles for the Wishbone to HyperBus bridge:
 * command FIFO entry, Wishbone request and response, native bus in and out
 */

package hbus_pkg;

  // User word, native beat and word address widths
  localparam int WORD_W = 32;
  localparam int BEAT_W = 16;
  localparam int ADR_W  = 24;

  // Native beats per user word
  localparam int BEATS = WORD_W / BEAT_W;

  // One entry of the command queue
  typedef struct packed {
    logic             we;
    logic [ADR_W-1:0] adr;
  } hbus_cmd_t;

  // Wishbone master to slave
  typedef struct packed {
    logic              cyc;
    logic              stb;
    logic              we;
    logic [ADR_W-1:0]  adr;
    logic [WORD_W-1:0] dat;
  } wb_req_t;

  // Wishbone slave to master
  typedef struct packed {
    logic              ack;
    logic [WORD_W-1:0] dat;
  } wb_rsp_t;

  // Bridge to HyperBus controller
  typedef struct packed {
    logic              rrq;
    logic              wrq;
    logic [ADR_W-1:0]  adr;
    logic [BEAT_W-1:0] dat;
  } hbus_out_t;

  // HyperBus controller to bridge
  typedef struct packed {
    logic              ready;
    logic              valid;
    logic [BEAT_W-1:0] dat;
  } hbus_in_t;

endpackage

// File: verilog/hbus_sync_fifo.sv
/*
 * Single clock FIFO with occupancy count and a combinational head entry,
 * used for the command, write data and read data queues
 */

`timescale 1ns/1ps

module hbus_sync_fifo #(
  parameter int WIDTH      = 32,
  parameter int DEPTH_LOG2 = 2
) (
  input  logic             clk,
  input  logic             hbus_rst,
  input  logic             push_i,
  input  logic [WIDTH-1:0] wdata_i,
  output logic             full_o,
  input  logic             pop_i,
  output logic [WIDTH-1:0] rdata_o,
  output logic             empty_o
);

  localparam int DEPTH = 1 << DEPTH_LOG2;

  logic [WIDTH-1:0]      mem [DEPTH];
  logic [DEPTH_LOG2-1:0] wr_ptr;
  logic [DEPTH_LOG2-1:0] rd_ptr;
  logic [DEPTH_LOG2:0]   count;

  assign full_o  = (count == (DEPTH_LOG2 + 1)'(DEPTH));
  assign empty_o = (count == '0);
  assign rdata_o = mem[rd_ptr];

  // Pointers wrap on their own since DEPTH is a power of two
  always_ff @(posedge clk or posedge hbus_rst) begin
    if (hbus_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_i)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop_i)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push_i, pop_i})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push_i)
      mem[wr_ptr] <= wdata_i;
  end

  a_no_push_full: assert property (@(posedge clk) disable iff (hbus_rst) push_i |-> !full_o);
  a_no_pop_empty: assert property (@(posedge clk) disable iff (hbus_rst) pop_i |-> !empty_o);

endmodule

// File: verilog/hbus_wb_front.sv
/*
 * Wishbone classic slave front end: turns each bus cycle into one queued
 * command, posts write data and returns read data with a registered ack
 */

`timescale 1ns/1ps

module hbus_wb_front (
  input  logic                        clk,
  input  logic                        hbus_rst,
  input  hbus_pkg::wb_req_t           wb_req_i,
  output hbus_pkg::wb_rsp_t           wb_rsp_o,
  output logic                        cmd_push_o,
  output hbus_pkg::hbus_cmd_t         cmd_o,
  input  logic                        cmd_full_i,
  output logic                        wdat_push_o,
  output logic [hbus_pkg::WORD_W-1:0] wdat_o,
  input  logic                        wdat_full_i,
  input  logic [hbus_pkg::WORD_W-1:0] rdat_i,
  input  logic                        rdat_empty_i,
  output logic                        rdat_pop_o
);

  localparam logic [1:0] ST_IDLE    = 2'd0;
  localparam logic [1:0] ST_WAIT_RD = 2'd1;
  localparam logic [1:0] ST_ACK     = 2'd2;

  logic [1:0] state_q;
  logic [1:0] state_d;
  logic       rd_q;
  logic       req_valid;
  logic       room;

  assign req_valid = wb_req_i.cyc && wb_req_i.stb;

  // Writes need a slot in both queues, reads only in the command queue
  assign room = !cmd_full_i && (!wb_req_i.we || !wdat_full_i);

  assign cmd_push_o  = (state_q == ST_IDLE) && req_valid && room;
  assign cmd_o       = '{we: wb_req_i.we, adr: wb_req_i.adr};
  assign wdat_push_o = cmd_push_o && wb_req_i.we;
  assign wdat_o      = wb_req_i.dat;

  // Read data leaves the queue in the ack cycle
  assign rdat_pop_o = (state_q == ST_ACK) && rd_q;

  assign wb_rsp_o = '{ack: (state_q == ST_ACK), dat: rdat_i};

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (cmd_push_o)
          state_d = wb_req_i.we ? ST_ACK : ST_WAIT_RD;
      end
      ST_WAIT_RD: begin
        if (!rdat_empty_i)
          state_d = ST_ACK;
      end
      ST_ACK:  state_d = ST_IDLE;
      default: state_d = ST_IDLE;
    endcase
  end

  // rd_q marks an ack that was reached through the read wait
  always_ff @(posedge clk or posedge hbus_rst) begin
    if (hbus_rst) begin
      state_q <= ST_IDLE;
      rd_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      rd_q    <= (state_q == ST_WAIT_RD);
    end
  end

  // Relies on the master holding stb until it sees ack
  a_ack_in_cycle: assert property (@(posedge clk) disable iff (hbus_rst)
    wb_rsp_o.ack |-> wb_req_i.cyc && wb_req_i.stb);

endmodule

// File: verilog/hbus_beat_seq.sv
/*
 * Native side sequencer: pops queued commands, sends write words as
 * high-first beats and packs returned read beats into words
 */

`timescale 1ns/1ps

module hbus_beat_seq (
  input  logic                        clk,
  input  logic                        hbus_rst,
  input  hbus_pkg::hbus_cmd_t         cmd_i,
  input  logic                        cmd_empty_i,
  output logic                        cmd_pop_o,
  input  logic [hbus_pkg::WORD_W-1:0] wdat_i,
  output logic                        wdat_pop_o,
  output logic [hbus_pkg::WORD_W-1:0] rdat_o,
  output logic                        rdat_push_o,
  input  logic                        rdat_full_i,
  output hbus_pkg::hbus_out_t         hbus_o,
  input  hbus_pkg::hbus_in_t          hbus_i
);

  localparam int WORD_W = hbus_pkg::WORD_W;
  localparam int BEAT_W = hbus_pkg::BEAT_W;
  localparam int BEATS  = hbus_pkg::BEATS;
  localparam int RX_W   = WORD_W - BEAT_W;
  localparam int CNT_W  = $clog2(BEATS + 1);

  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_READ  = 2'd1;
  localparam logic [1:0] ST_WRITE = 2'd2;

  logic [1:0]                 state_q;
  logic [CNT_W-1:0]           beat_cnt_q;
  logic [hbus_pkg::ADR_W-1:0] adr_q;
  logic [WORD_W-1:0]          tx_shift_q;
  logic [RX_W-1:0]            rx_shift_q;
  logic                       start;
  logic                       last_beat;
  logic                       wr_beat;
  logic                       rd_beat;

  // A read only starts when its word is sure to find a slot
  assign start = (state_q == ST_IDLE) && !cmd_empty_i && (cmd_i.we || !rdat_full_i);

  assign last_beat = (beat_cnt_q == CNT_W'(1));
  assign wr_beat   = (state_q == ST_WRITE) && hbus_i.ready;
  assign rd_beat   = (state_q == ST_READ) && hbus_i.valid;

  assign cmd_pop_o   = start;
  assign wdat_pop_o  = wr_beat && last_beat;
  assign rdat_push_o = rd_beat && last_beat;

  // Final beat joins the gathered ones straight from the bus
  assign rdat_o = {rx_shift_q, hbus_i.dat};

  assign hbus_o = '{
    rrq: (state_q == ST_READ),
    wrq: (state_q == ST_WRITE),
    adr: adr_q,
    dat: tx_shift_q[WORD_W-1 -: BEAT_W]
  };

  always_ff @(posedge clk or posedge hbus_rst) begin
    if (hbus_rst) begin
      state_q    <= ST_IDLE;
      beat_cnt_q <= '0;
    end else begin
      if (start) begin
        state_q    <= cmd_i.we ? ST_WRITE : ST_READ;
        beat_cnt_q <= CNT_W'(BEATS);
      end else if (wr_beat || rd_beat) begin
        beat_cnt_q <= beat_cnt_q - 1'b1;
        if (last_beat)
          state_q <= ST_IDLE;
      end
    end
  end

  // Address and beat shifters
  always_ff @(posedge clk) begin
    if (start) begin
      adr_q <= cmd_i.adr;
      if (cmd_i.we)
        tx_shift_q <= wdat_i;
    end else if (wr_beat) begin
      tx_shift_q <= tx_shift_q << BEAT_W;
    end
    if (rd_beat)
      rx_shift_q <= RX_W'({rx_shift_q, hbus_i.dat});
  end

endmodule

// File: verilog/hbus_bridge.sv
/*
 * Top level: Wishbone front end, command, write data and read data FIFOs,
 * and the native bus sequencer
 */

`timescale 1ns/1ps

module hbus_bridge #(
  parameter int DEPTH_LOG2 = 2
) (
  input  logic                clk,
  input  logic                hbus_rst,
  input  hbus_pkg::wb_req_t   wb_req_i,
  output hbus_pkg::wb_rsp_t   wb_rsp_o,
  output hbus_pkg::hbus_out_t hbus_o,
  input  hbus_pkg::hbus_in_t  hbus_i
);

  localparam int CMD_W = $bits(hbus_pkg::hbus_cmd_t);

  hbus_pkg::hbus_cmd_t         cmd_wr;
  hbus_pkg::hbus_cmd_t         cmd_rd;
  logic                        cmd_push;
  logic                        cmd_pop;
  logic                        cmd_full;
  logic                        cmd_empty;
  logic [hbus_pkg::WORD_W-1:0] wdat_wr;
  logic [hbus_pkg::WORD_W-1:0] wdat_rd;
  logic                        wdat_push;
  logic                        wdat_pop;
  logic                        wdat_full;
  logic [hbus_pkg::WORD_W-1:0] rdat_wr;
  logic [hbus_pkg::WORD_W-1:0] rdat_rd;
  logic                        rdat_push;
  logic                        rdat_pop;
  logic                        rdat_full;
  logic                        rdat_empty;

  hbus_wb_front u_front (
    .clk          (clk),
    .hbus_rst     (hbus_rst),
    .wb_req_i     (wb_req_i),
    .wb_rsp_o     (wb_rsp_o),
    .cmd_push_o   (cmd_push),
    .cmd_o        (cmd_wr),
    .cmd_full_i   (cmd_full),
    .wdat_push_o  (wdat_push),
    .wdat_o       (wdat_wr),
    .wdat_full_i  (wdat_full),
    .rdat_i       (rdat_rd),
    .rdat_empty_i (rdat_empty),
    .rdat_pop_o   (rdat_pop)
  );

  hbus_sync_fifo #(.WIDTH(CMD_W), .DEPTH_LOG2(DEPTH_LOG2)) cmd_fifo (
    .clk      (clk),
    .hbus_rst (hbus_rst),
    .push_i   (cmd_push),
    .wdata_i  (cmd_wr),
    .full_o   (cmd_full),
    .pop_i    (cmd_pop),
    .rdata_o  (cmd_rd),
    .empty_o  (cmd_empty)
  );

  // Write data always sits behind a queued write command
  hbus_sync_fifo #(.WIDTH(hbus_pkg::WORD_W), .DEPTH_LOG2(DEPTH_LOG2)) wdat_fifo (
    .clk      (clk),
    .hbus_rst (hbus_rst),
    .push_i   (wdat_push),
    .wdata_i  (wdat_wr),
    .full_o   (wdat_full),
    .pop_i    (wdat_pop),
    .rdata_o  (wdat_rd),
    .empty_o  ()
  );

  hbus_sync_fifo #(.WIDTH(hbus_pkg::WORD_W), .DEPTH_LOG2(DEPTH_LOG2)) rdat_fifo (
    .clk      (clk),
    .hbus_rst (hbus_rst),
    .push_i   (rdat_push),
    .wdata_i  (rdat_wr),
    .full_o   (rdat_full),
    .pop_i    (rdat_pop),
    .rdata_o  (rdat_rd),
    .empty_o  (rdat_empty)
  );

  hbus_beat_seq u_seq (
    .clk         (clk),
    .hbus_rst    (hbus_rst),
    .cmd_i       (cmd_rd),
    .cmd_empty_i (cmd_empty),
    .cmd_pop_o   (cmd_pop),
    .wdat_i      (wdat_rd),
    .wdat_pop_o  (wdat_pop),
    .rdat_o      (rdat_wr),
    .rdat_push_o (rdat_push),
    .rdat_full_i (rdat_full),
    .hbus_o      (hbus_o),
    .hbus_i      (hbus_i)
  );

endmodule

// File: bench/hbus_bridge_checker.sv
/*
 * Bridge checker: reference word memory, ack and read data checks,
 * native command order and beat framing, per test and total reports
 */

`timescale 1ns/1ps

module hbus_bridge_checker (
  input  logic                clk,
  input  logic                hbus_rst,
  input  hbus_pkg::wb_req_t   wb_req_i,
  input  hbus_pkg::wb_rsp_t   wb_rsp_i,
  input  hbus_pkg::hbus_out_t hb_out_i,
  input  hbus_pkg::hbus_in_t  hb_in_i,
  output logic                drained_o
);

  localparam int WORD_W = hbus_pkg::WORD_W;
  localparam int BEAT_W = hbus_pkg::BEAT_W;

  // Expected native request, dat is the word that must move
  typedef struct packed {
    logic                       we;
    logic [hbus_pkg::ADR_W-1:0] adr;
    logic [WORD_W-1:0]          dat;
  } exp_cmd_t;

  logic [WORD_W-1:0] model [logic [hbus_pkg::ADR_W-1:0]];
  exp_cmd_t          cmd_q [$];
  logic [WORD_W-1:0] rd_q [$];
  exp_cmd_t          cur;
  logic [WORD_W-1:0] acc;
  logic [WORD_W-1:0] exp_rd;
  logic              pending = 1'b0;
  logic              in_ep = 1'b0;
  logic              rst_tail = 1'b1;
  int                nbeats = 0;
  int                err_cnt = 0;
  int                err_mark = 0;
  int                tests = 0;
  int                failed = 0;
  int                episodes = 0;
  int                frame_err = 0;
  int                issued = 0;
  int                acked = 0;

  // Unwritten words read back as their address with a fixed mask
  function automatic logic [WORD_W-1:0] model_read(input logic [hbus_pkg::ADR_W-1:0] adr);
    if (model.exists(adr))
      return model[adr];
    return WORD_W'(adr) ^ 32'h5a5a0000;
  endfunction

  task automatic value_error(input string name, input logic [WORD_W-1:0] exp,
                             input logic [WORD_W-1:0] got);
    err_cnt++;
    $display("Error at %0t ns: %s expected %h got %h", $time, name, exp, got);
  endtask

  task automatic frame_error(input string name, input logic [WORD_W-1:0] exp,
                             input logic [WORD_W-1:0] got);
    frame_err++;
    value_error(name, exp, got);
  endtask

  task automatic note_failure(input string what);
    err_cnt++;
    $display("Failure at %0t ns: %s", $time, what);
  endtask

  always @(negedge clk) begin
    if ((hbus_rst || rst_tail) && (wb_rsp_i.ack || hb_out_i.rrq || hb_out_i.wrq))
      value_error("{ack,rrq,wrq}", '0, WORD_W'({wb_rsp_i.ack, hb_out_i.rrq, hb_out_i.wrq}));
    rst_tail = hbus_rst;
    if (hbus_rst) begin
      pending = 1'b0;
      in_ep = 1'b0;
    end else begin
      // Issue order is execution order, so the model moves at issue
      if (wb_req_i.cyc && wb_req_i.stb && !pending) begin
        pending = 1'b1;
        issued++;
        if (wb_req_i.we)
          model[wb_req_i.adr] = wb_req_i.dat;
        cmd_q.push_back('{we: wb_req_i.we, adr: wb_req_i.adr, dat: model_read(wb_req_i.adr)});
        if (!wb_req_i.we)
          rd_q.push_back(model_read(wb_req_i.adr));
      end
      if (wb_rsp_i.ack) begin
        acked++;
        if (!pending) begin
          note_failure("ack seen with no request outstanding");
        end else if (!wb_req_i.we) begin
          exp_rd = rd_q.pop_front();
          if (wb_rsp_i.dat !== exp_rd)
            value_error("wb_rsp_o.dat", exp_rd, wb_rsp_i.dat);
        end
        pending = 1'b0;
      end
      if (hb_out_i.rrq && hb_out_i.wrq)
        note_failure("rrq and wrq are high together");
      if (in_ep && !hb_out_i.rrq && !hb_out_i.wrq) begin
        in_ep = 1'b0;
        episodes++;
        if (nbeats != hbus_pkg::BEATS) begin
          frame_err++;
          note_failure($sformatf("%0d beats moved in one native request", nbeats));
        end
        if (acc !== cur.dat)
          frame_error(cur.we ? "hbus_o.dat word" : "hbus_i.dat word", cur.dat, acc);
      end
      if (!in_ep && (hb_out_i.rrq || hb_out_i.wrq)) begin
        in_ep = 1'b1;
        nbeats = 0;
        acc = '0;
        if (cmd_q.size() == 0) begin
          note_failure("native request with no command issued");
          cur = '{we: hb_out_i.wrq, adr: hb_out_i.adr, dat: '0};
        end else begin
          cur = cmd_q.pop_front();
        end
        if (hb_out_i.wrq !== cur.we)
          frame_error("hbus_o.wrq", WORD_W'(cur.we), WORD_W'(hb_out_i.wrq));
        if (hb_out_i.adr !== cur.adr)
          frame_error("hbus_o.adr", WORD_W'(cur.adr), WORD_W'(hb_out_i.adr));
      end
      // High half arrives first, so shifting left rebuilds the word
      if (in_ep && (cur.we ? hb_out_i.wrq && hb_in_i.ready : hb_out_i.rrq && hb_in_i.valid)) begin
        acc = {acc[WORD_W-BEAT_W-1:0], cur.we ? hb_out_i.dat : hb_in_i.dat};
        nbeats++;
      end
    end
    drained_o = !pending && !in_ep && (cmd_q.size() == 0);
  end

  task automatic end_test(input string name);
    int n;
    n = err_cnt - err_mark;
    err_mark = err_cnt;
    tests++;
    if (n != 0)
      failed++;
    $display("Test %0d %s: %s, %0d errors", tests, name, (n == 0) ? "ok" : "failed", n);
  endtask

  task automatic end_framing_test();
    tests++;
    if (frame_err != 0)
      failed++;
    $display("Test %0d beat framing: %s, %0d native requests, %0d errors", tests,
             (frame_err == 0) ? "ok" : "failed", episodes, frame_err);
  endtask

  task automatic print_totals(output int total);
    total = err_cnt;
    if (issued != acked || cmd_q.size() != 0 || rd_q.size() != 0) begin
      total++;
      $display("Requests left without ack or native transfer at the end of the run");
    end
    $display("Tests run: %0d, failed: %0d, errors: %0d, requests: %0d, acks: %0d",
             tests, failed, total, issued, acked);
  endtask

endmodule

// File: bench/hbus_bridge_tb.sv
/*
 * Testbench for the Wishbone to HyperBus bridge: clock and reset, seeded
 * random Wishbone master, native bus responder with stalls, watchdog
 */

`timescale 1ns/1ps

module hbus_bridge_tb;

  localparam int WORD_W = hbus_pkg::WORD_W;
  localparam int BEAT_W = hbus_pkg::BEAT_W;
  localparam int ADR_W  = hbus_pkg::ADR_W;
  localparam int BEATS  = hbus_pkg::BEATS;
  localparam int N_RW   = 16;
  localparam int N_MIX  = 200;
  localparam int WATCHDOG_CYCLES = (3 * N_RW + N_MIX) * 64;

  logic                clk = 1'b0;
  logic                hbus_rst = 1'b1;
  hbus_pkg::wb_req_t   wb_req;
  hbus_pkg::wb_rsp_t   wb_rsp;
  hbus_pkg::hbus_out_t hb_out;
  hbus_pkg::hbus_in_t  hb_in;
  logic                drained;
  integer              seed = 32'h363277ea;
  logic [6:0]          stall_lvl = 7'd32;
  logic [WORD_W-1:0]   nat_mem [logic [ADR_W-1:0]];

  hbus_bridge #(.DEPTH_LOG2(2)) dut (
    .clk      (clk),
    .hbus_rst (hbus_rst),
    .wb_req_i (wb_req),
    .wb_rsp_o (wb_rsp),
    .hbus_o   (hb_out),
    .hbus_i   (hb_in)
  );

  hbus_bridge_checker chk (
    .clk       (clk),
    .hbus_rst  (hbus_rst),
    .wb_req_i  (wb_req),
    .wb_rsp_i  (wb_rsp),
    .hb_out_i  (hb_out),
    .hb_in_i   (hb_in),
    .drained_o (drained)
  );

  initial begin
    forever #2 clk = ~clk;
  end

  // Holds the request until ack, then returns in the ack cycle
  task automatic issue_request(input logic we, input logic [ADR_W-1:0] adr,
                               input logic [WORD_W-1:0] dat);
    @(posedge clk);
    wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
    @(negedge clk);
    while (!wb_rsp.ack)
      @(negedge clk);
  endtask

  task automatic bus_idle();
    @(posedge clk);
    wb_req <= '0;
  endtask

  // Controller model, valid only rises inside a read that is already seen
  initial begin : responder
    logic [31:0]       r;
    logic [WORD_W-1:0] word;
    logic [WORD_W-1:0] wr_acc;
    logic              rd_done;
    int                rd_idx;
    int                wr_idx;
    hb_in = '0;
    wr_acc = '0;
    rd_idx = 0;
    wr_idx = 0;
    forever begin
      @(posedge clk);
      if (hb_out.wrq && hb_in.ready) begin
        wr_acc = {wr_acc[WORD_W-BEAT_W-1:0], hb_out.dat};
        wr_idx++;
        if (wr_idx == BEATS) begin
          nat_mem[hb_out.adr] = wr_acc;
          wr_idx = 0;
        end
      end
      rd_done = 1'b0;
      if (hb_out.rrq && hb_in.valid) begin
        rd_idx++;
        if (rd_idx == BEATS) begin
          rd_idx = 0;
          rd_done = 1'b1;
        end
      end
      word = nat_mem.exists(hb_out.adr) ? nat_mem[hb_out.adr]
                                        : WORD_W'(hb_out.adr) ^ 32'h5a5a0000;
      r = $random(seed);
      hb_in <= '{ready: r[6:0] >= stall_lvl,
                 valid: hb_out.rrq && !rd_done && (r[13:7] >= stall_lvl),
                 dat:   BEAT_W'(word >> ((BEATS - 1 - rd_idx) * BEAT_W))};
    end
  end

  initial begin : stimulus
    logic [31:0]      r;
    logic [ADR_W-1:0] adrs [N_RW];
    int               errors;
    wb_req = '0;
    repeat (3) @(posedge clk);
    hbus_rst <= 1'b0;
    repeat (2) @(posedge clk);
    chk.end_test("reset state");
    for (int i = 0; i < N_RW; i++) begin
      r = $random(seed);
      adrs[i] = {1'b0, r[ADR_W-2:0]};
      issue_request(1'b1, adrs[i], $random(seed));
    end
    for (int i = 0; i < N_RW; i++)
      issue_request(1'b0, adrs[i], '0);
    bus_idle();
    chk.end_test("write then read back");
    // Upper half of the space is never written
    for (int i = 0; i < N_RW; i++) begin
      r = $random(seed);
      issue_request(1'b0, {1'b1, r[ADR_W-2:0]}, '0);
    end
    bus_idle();
    chk.end_test("unwritten addresses");
    stall_lvl <= 7'd88;
    for (int i = 0; i < N_MIX; i++) begin
      r = $random(seed);
      issue_request(r[0], {21'h100000, r[3:1]}, $random(seed));
      if (r[5:4] == 2'b11)
        bus_idle();
    end
    bus_idle();
    while (!drained)
      @(posedge clk);
    chk.end_test("back-pressure and ordering");
    chk.end_framing_test();
    chk.print_totals(errors);
    if (errors == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, a request never completed", WATCHDOG_CYCLES);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// File: hbus_bridge.f
verilog/hbus_pkg.sv
verilog/hbus_sync_fifo.sv
verilog/hbus_wb_front.sv
verilog/hbus_beat_seq.sv
verilog/hbus_bridge.sv
bench/hbus_bridge_checker.sv
bench/hbus_bridge_tb.sv

// File: Makefile
# Verilator build and run of the bridge testbench

SIM  := obj_dir/Vhbus_bridge_tb
SRCS := $(filter %.sv %.v,$(shell cat hbus_bridge.f))

.PHONY: all run clean

all: $(SIM)

$(SIM): hbus_bridge.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps \
	  --top-module hbus_bridge_tb -f hbus_bridge.f

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; \
	  echo "$$out" | grep -qx 'Simulation finished: PASS'

clean:
	rm -rf obj_dir
